// File: logic/mem_pkg.sv
package mem_pkg;

  // default geometry of the memory
  localparam int DEF_WIDTH   = 16;  // bits per word
  localparam int DEF_NUMVBNK = 4;   // virtual banks, need not be a power of two
  localparam int DEF_NUMVROW = 8;   // rows per bank

  // where the write of the current cycle lands
  typedef enum logic {
    ROUTE_HOME  = 1'b0,  // mapped bank of the virtual bank
    ROUTE_SPARE = 1'b1   // spare bank of the row, map swaps
  } wr_route_e;

endpackage

// File: logic/bank_if.sv
`timescale 1ns/1ps

interface bank_if #(
  parameter int WIDTH   = 16,
  parameter int BITPBNK = 3,
  parameter int BITVROW = 3
) (
  input logic clk
);

  // write port
  logic               wr_en;
  logic [BITPBNK-1:0] wr_bank;
  logic [BITVROW-1:0] wr_row;
  logic [WIDTH-1:0]   wr_data;

  // read port, data one cycle after rd_en
  logic               rd_en;
  logic [BITPBNK-1:0] rd_bank;
  logic [BITVROW-1:0] rd_row;
  logic [WIDTH-1:0]   rd_data;

  modport ctrl (
    output wr_en, wr_bank, wr_row, wr_data,
    output rd_en, rd_bank, rd_row,
    input  rd_data
  );

  modport array (
    input  clk,
    input  wr_en, wr_bank, wr_row, wr_data,
    input  rd_en, rd_bank, rd_row,
    output rd_data
  );

endinterface

// File: logic/bank_array.sv
`timescale 1ns/1ps

module bank_array #(
  parameter int WIDTH   = 16,
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 8,
  localparam int NUMPBNK = NUMVBNK + 1
) (
  input logic   clk,
  bank_if.array bank
);

  // one array per physical bank, the extra one serves as spare
  logic [WIDTH-1:0] mem [NUMPBNK][NUMVROW];

  // write side
  always_ff @(posedge clk) begin
    if (bank.wr_en) begin
      mem[bank.wr_bank][bank.wr_row] <= bank.wr_data;
    end
  end

  // read side, registered output
  // ctrl never hits the bank being written in the same cycle
  always_ff @(posedge clk) begin
    if (bank.rd_en) begin
      bank.rd_data <= mem[bank.rd_bank][bank.rd_row];  // holds when idle
    end
  end

endmodule

// File: logic/map_table.sv
`timescale 1ns/1ps

module map_table import mem_pkg::*; #(
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 8,
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITPBNK = $clog2(NUMPBNK),
  localparam int BITVROW = $clog2(NUMVROW)
) (
  input  logic               clk,
  input  logic               rst,
  // read lookup
  input  logic [BITVROW-1:0] rd_row,
  input  logic [BITVBNK-1:0] rd_vbank,
  output logic [BITPBNK-1:0] rd_pbank,
  // write lookup and update
  input  logic [BITVROW-1:0] wr_row,
  input  logic [BITVBNK-1:0] wr_vbank,
  output logic [BITPBNK-1:0] wr_pbank,
  output logic [BITPBNK-1:0] wr_spare,
  input  wr_route_e          upd_route
);

  // entries 0..NUMVBNK-1 map virtual banks, entry NUMVBNK is the spare
  logic [BITPBNK-1:0] map [NUMVROW][NUMPBNK];

  logic               swap;
  logic [BITPBNK-1:0] new_home;  // physical bank taking the written data
  logic [BITPBNK-1:0] new_spare;

  // combinational lookups
  assign rd_pbank = map[rd_row][rd_vbank];
  assign wr_pbank = map[wr_row][wr_vbank];
  assign wr_spare = map[wr_row][NUMVBNK];

  assign swap      = (upd_route == ROUTE_SPARE);
  assign new_home  = wr_spare;
  assign new_spare = wr_pbank;  // stale copy lives here now

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUMVROW; r++) begin
        for (int b = 0; b < NUMPBNK; b++) begin
          map[r][b] <= BITPBNK'(b);  // identity
        end
      end
    end else if (swap) begin
      // exchange two entries, row stays a permutation
      map[wr_row][wr_vbank] <= new_home;
      map[wr_row][NUMVBNK]  <= new_spare;
    end
  end

endmodule

// File: logic/remap_ctrl.sv
`timescale 1ns/1ps

module remap_ctrl import mem_pkg::*; #(
  parameter int WIDTH   = 16,
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 8,
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int NUMADDR = NUMVBNK * NUMVROW,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITPBNK = $clog2(NUMPBNK),
  localparam int BITVROW = $clog2(NUMVROW)
) (
  input  logic               clk,
  input  logic               rst,
  // user side
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  logic [WIDTH-1:0]   din,
  input  logic               read,
  input  logic [BITADDR-1:0] rd_adr,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_dout,
  // map table
  output logic [BITVROW-1:0] rd_row,
  output logic [BITVBNK-1:0] rd_vbank,
  input  logic [BITPBNK-1:0] rd_pbank,
  output logic [BITVROW-1:0] wr_row,
  output logic [BITVBNK-1:0] wr_vbank,
  input  logic [BITPBNK-1:0] wr_pbank,
  input  logic [BITPBNK-1:0] wr_spare,
  output wr_route_e          upd_route,
  // physical banks
  bank_if.ctrl               bank
);

  logic [BITVROW-1:0] wr_row_in;
  logic [BITVBNK-1:0] wr_vbank_in;
  logic [BITVROW-1:0] rd_row_in;
  logic [BITVBNK-1:0] rd_vbank_in;

  logic               write_s1;
  logic               read_s1;
  logic [WIDTH-1:0]   din_s1;
  logic               conflict;

  // split into virtual bank (mod) and row (div)
  assign wr_vbank_in = BITVBNK'(wr_adr % NUMVBNK);
  assign wr_row_in   = BITVROW'(wr_adr / NUMVBNK);
  assign rd_vbank_in = BITVBNK'(rd_adr % NUMVBNK);
  assign rd_row_in   = BITVROW'(rd_adr / NUMVBNK);

  // stage 1 strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      write_s1 <= 1'b0;
      read_s1  <= 1'b0;
    end else begin
      write_s1 <= write;
      read_s1  <= read;
    end
  end

  // stage 1 payload
  always_ff @(posedge clk) begin
    wr_row   <= wr_row_in;
    wr_vbank <= wr_vbank_in;
    din_s1   <= din;
    rd_row   <= rd_row_in;
    rd_vbank <= rd_vbank_in;
  end

  // both ports would hit one physical bank
  assign conflict  = write_s1 && read_s1 && (wr_pbank == rd_pbank);
  assign upd_route = conflict ? ROUTE_SPARE : ROUTE_HOME;

  // bank commands, read keeps the mapped bank
  assign bank.wr_en   = write_s1;
  assign bank.wr_bank = (upd_route == ROUTE_SPARE) ? wr_spare : wr_pbank;
  assign bank.wr_row  = wr_row;
  assign bank.wr_data = din_s1;
  assign bank.rd_en   = read_s1;
  assign bank.rd_bank = rd_pbank;
  assign bank.rd_row  = rd_row;

  // stage 2, bank data is already registered
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= read_s1;
    end
  end

  assign rd_dout = bank.rd_data;

endmodule

// File: logic/mem_1r1w_top.sv
`timescale 1ns/1ps

module mem_1r1w_top import mem_pkg::*; #(
  parameter int WIDTH   = DEF_WIDTH,
  parameter int NUMVBNK = DEF_NUMVBNK,
  parameter int NUMVROW = DEF_NUMVROW,
  localparam int NUMPBNK = NUMVBNK + 1,
  localparam int NUMADDR = NUMVBNK * NUMVROW,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITPBNK = $clog2(NUMPBNK),
  localparam int BITVROW = $clog2(NUMVROW)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  logic [WIDTH-1:0]   din,
  input  logic               read,
  input  logic [BITADDR-1:0] rd_adr,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_dout
);

  logic [BITVROW-1:0] rd_row;
  logic [BITVBNK-1:0] rd_vbank;
  logic [BITPBNK-1:0] rd_pbank;
  logic [BITVROW-1:0] wr_row;
  logic [BITVBNK-1:0] wr_vbank;
  logic [BITPBNK-1:0] wr_pbank;
  logic [BITPBNK-1:0] wr_spare;
  wr_route_e          upd_route;

  bank_if #(
    .WIDTH   (WIDTH),
    .BITPBNK (BITPBNK),
    .BITVROW (BITVROW)
  ) bank_bus (
    .clk (clk)
  );

  remap_ctrl #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) remap_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_row    (rd_row),
    .rd_vbank  (rd_vbank),
    .rd_pbank  (rd_pbank),
    .wr_row    (wr_row),
    .wr_vbank  (wr_vbank),
    .wr_pbank  (wr_pbank),
    .wr_spare  (wr_spare),
    .upd_route (upd_route),
    .bank      (bank_bus.ctrl)
  );

  map_table #(
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) map_table_inst (
    .clk       (clk),
    .rst       (rst),
    .rd_row    (rd_row),
    .rd_vbank  (rd_vbank),
    .rd_pbank  (rd_pbank),
    .wr_row    (wr_row),
    .wr_vbank  (wr_vbank),
    .wr_pbank  (wr_pbank),
    .wr_spare  (wr_spare),
    .upd_route (upd_route)
  );

  bank_array #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) bank_array_inst (
    .clk  (clk),
    .bank (bank_bus.array)
  );

endmodule

// File: bench/mem_1r1w_asserts.sv
`timescale 1ns/1ps

module mem_1r1w_asserts #(
  parameter int BITPBNK = 3
) (
  input logic               clk,
  input logic               rst,
  input logic               read,
  input logic               rd_vld,
  input logic               wr_en,
  input logic               rd_en,
  input logic [BITPBNK-1:0] wr_bank,
  input logic [BITPBNK-1:0] rd_bank
);

  // both ports active never land on one physical bank
  bank_split: assert property (@(posedge clk) disable iff (rst)
    (wr_en && rd_en) |-> (wr_bank != rd_bank))
    else $error("write and read both on physical bank %0d", rd_bank);

  // fixed read latency of two cycles
  vld_latency: assert property (@(posedge clk) disable iff (rst)
    rd_vld == $past(read, 2))
    else $error("rd_vld does not follow read by two cycles");

  vld_after_reset: assert property (@(posedge clk)
    $past(rst) |-> !rd_vld)
    else $error("rd_vld high right after reset");

endmodule

// File: bench/tb_mem_1r1w.sv
`timescale 1ns/1ps

module tb_mem_1r1w import mem_pkg::*;;

  localparam int WIDTH          = DEF_WIDTH;
  localparam int NUMVBNK        = DEF_NUMVBNK;
  localparam int NUMVROW        = DEF_NUMVROW;
  localparam int NUMADDR        = NUMVBNK * NUMVROW;
  localparam int BITADDR        = $clog2(NUMADDR);
  localparam int RAND_CYCLES    = 200;
  localparam int TEST_CYCLES    = 2 + NUMADDR + RAND_CYCLES + 60;  // rough sum of all tests
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

  logic               clk;
  logic               rst;
  logic               write;
  logic [BITADDR-1:0] wr_adr;
  logic [WIDTH-1:0]   din;
  logic               read;
  logic [BITADDR-1:0] rd_adr;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_dout;

  logic [WIDTH-1:0]   shadow [NUMADDR];  // reference contents by virtual address
  logic [WIDTH-1:0]   exp_q [$];         // expected data of reads in flight
  logic [1:0]         vld_pipe = 2'b00;  // read strobes of the last two cycles
  int                 cycle_count = 0;
  integer             seed = 32'h69deb42f;

  mem_1r1w_top #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) mem_1r1w_top_inst (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  bind remap_ctrl mem_1r1w_asserts #(
    .BITPBNK (BITPBNK)
  ) mem_1r1w_asserts_inst (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .rd_vld  (rd_vld),
    .wr_en   (bank.wr_en),
    .rd_en   (bank.rd_en),
    .wr_bank (bank.wr_bank),
    .rd_bank (bank.rd_bank)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // response checker, samples half a cycle after the edge
  always @(negedge clk) begin
    logic [WIDTH-1:0] exp_data;
    if (rst !== 1'b0) begin
      vld_pipe = 2'b00;
    end else begin
      assert (rd_vld === vld_pipe[1]) else begin
        $display("Error: %0t ns: rd_vld is %b, expected %b", $time, rd_vld, vld_pipe[1]);
        $display("TESTS FAILED");
        $fatal(1, "rd_vld mismatch");
      end
      if (rd_vld === 1'b1) begin
        exp_data = exp_q.pop_front();
        assert (rd_dout === exp_data) else begin
          $display("Error: %0t ns: rd_dout is %h, expected %h", $time, rd_dout, exp_data);
          $display("TESTS FAILED");
          $fatal(1, "read data mismatch");
        end
      end
      vld_pipe = {vld_pipe[0], read};
    end
  end

  function automatic logic [WIDTH-1:0] fill_word(input int adr);
    return WIDTH'((adr * 32'h9e37) ^ 32'h5a5a);
  endfunction

  // one cycle of requests, read sees the contents before this write
  task automatic drive_cycle(input logic wr, input logic [BITADDR-1:0] wa,
                             input logic [WIDTH-1:0] wd, input logic rd,
                             input logic [BITADDR-1:0] ra);
    @(posedge clk);
    write  <= wr;
    wr_adr <= wa;
    din    <= wd;
    read   <= rd;
    rd_adr <= ra;
    if (rd) exp_q.push_back(shadow[ra]);
    if (wr) shadow[wa] = wd;
  endtask

  task automatic wait_drained();
    drive_cycle(1'b0, '0, '0, 1'b0, '0);
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic check_reset_idle();
    repeat (4) begin
      @(negedge clk);
      assert (rd_vld === 1'b0) else begin
        $display("Error: %0t ns: rd_vld high after reset with no read", $time);
        $display("TESTS FAILED");
        $fatal(1, "rd_vld after reset");
      end
    end
  endtask

  task automatic fill_memory();
    for (int a = 0; a < NUMADDR; a++) begin
      drive_cycle(1'b1, BITADDR'(a), fill_word(a), 1'b0, '0);
    end
    wait_drained();
  endtask

  task automatic write_then_read();
    drive_cycle(1'b1, 5'd3, 16'hbeef, 1'b0, '0);
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd3);
    drive_cycle(1'b1, 5'd30, 16'h1234, 1'b1, 5'd3);
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd30);
    wait_drained();
  endtask

  // same virtual bank, different rows, write goes to the spare
  task automatic conflict_reroute();
    drive_cycle(1'b1, 5'd9, 16'hc0de, 1'b1, 5'd21);
    drive_cycle(1'b1, 5'd21, 16'hface, 1'b1, 5'd9);
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd9);
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd21);
    drive_cycle(1'b1, 5'd5, 16'h0f0f, 1'b1, 5'd1);
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd5);
    wait_drained();
  endtask

  task automatic same_address_same_cycle();
    drive_cycle(1'b1, 5'd13, 16'h7777, 1'b1, 5'd13);  // old value expected
    drive_cycle(1'b0, '0, '0, 1'b1, 5'd13);
    wait_drained();
  endtask

  task automatic random_stream();
    logic               wr;
    logic               rd;
    logic [BITADDR-1:0] wa;
    logic [BITADDR-1:0] ra;
    logic [WIDTH-1:0]   wd;
    int                 row;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      wr  = ($random(seed) & 3) != 0;
      rd  = ($random(seed) & 3) != 0;
      ra  = BITADDR'($unsigned($random(seed)) % NUMADDR);
      wd  = WIDTH'($random(seed));
      row = int'($unsigned($random(seed)) % NUMVROW);
      if (($random(seed) & 1) != 0) begin
        wa = BITADDR'(row * NUMVBNK + int'(ra) % NUMVBNK);  // same virtual bank
      end else begin
        wa = BITADDR'($unsigned($random(seed)) % NUMADDR);
      end
      drive_cycle(wr, wa, wd, rd, ra);
    end
    wait_drained();
  endtask

  initial begin
    rst    <= 1'b1;
    write  <= 1'b0;
    wr_adr <= '0;
    din    <= '0;
    read   <= 1'b0;
    rd_adr <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    check_reset_idle();
    fill_memory();
    write_then_read();
    conflict_reroute();
    same_address_same_cycle();
    random_stream();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: tb.f
logic/mem_pkg.sv
logic/bank_if.sv
logic/bank_array.sv
logic/map_table.sv
logic/remap_ctrl.sv
logic/mem_1r1w_top.sv
bench/mem_1r1w_asserts.sv
bench/tb_mem_1r1w.sv

// File: run.sh
#!/bin/sh
# build with Verilator, then run and look for the pass line
verilator --binary --assert --timing --timescale 1ns/1ps -f tb.f --top-module tb_mem_1r1w \
  && ./obj_dir/Vtb_mem_1r1w | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
